// ==== design/dvk_board_pkg.sv ====
//**************************************************
// dvk_board shared definitions
// bus types, cpu request struct, address windows
// and power-up constants of the processor board
//**************************************************

package dvk_board_pkg;

  // basic bus widths
  typedef logic [15:0] word_t;       // data word
  typedef logic [15:0] addr_t;       // byte address
  typedef logic [1:0]  byte_sel_t;   // byte lanes
  typedef logic [11:0] rom_index_t;  // rom word index, adr[12:1]

  // wishbone master request from the cpu core
  typedef struct packed {
    addr_t     adr;  // address
    word_t     dat;  // write data
    logic      we;   // write enable
    byte_sel_t sel;  // byte select
    logic      cyc;  // bus cycle
    logic      stb;  // data strobe
  } wb_req_t;

  //**************************************************
  // startup register (SEL1) load value
  //**************************************************
  // mode 00 vector 24, 01 console, 10 boot DX, 11 start at 140000
  localparam logic [1:0] STARTUP_MODE  = 2'b01;
  // start address 340 in high byte, low rom window on
  localparam word_t      STARTUP_RESET = {8'o340, 5'b00000, 1'b1, STARTUP_MODE};
  localparam logic       TIMER_INIT    = 1'b1;  // timer on after reset

  // address windows
  localparam addr_t      CPUDEV_BASE   = 16'o177700;  // cpu register block
  localparam addr_t      SYSRAM_BASE   = 16'o177600;  // system ram window
  localparam logic [2:0] ROM_PAGE      = 3'b111;      // 160000-177777

  // shadow rom image
  localparam int    ROM_WORDS = 4096;
  localparam string ROM_IMAGE = "design/shadow_rom.hex";

  // dividers
  localparam int CPU_ENA_DIV      = 22;       // cpu clock enable period
  localparam int CPU_ENA_W        = $clog2(CPU_ENA_DIV);
  localparam int TICK_DIV_DEFAULT = 2000000;  // 50 Hz at 100 MHz

endpackage

// ==== design/bus_decode.sv ====
//**************************************************
// bus_decode
// cpu address decode, external cycle gating,
// read data select and ack merge
//**************************************************
`timescale 1ns/10ps

module bus_decode
  import dvk_board_pkg::*;
(
  input  wb_req_t req_i,          // cpu request
  input  word_t   startup_reg_i,  // SEL1, bits 3:2 steer the rom
  // shadow rom
  input  word_t   rom_dat_i,
  input  logic    rom_ack_i,
  output logic    rom_stb_o,
  // cpu register block 177700-177717
  input  word_t   cpudev_dat_i,
  input  logic    cpudev_ack_i,
  output logic    cpudev_stb_o,
  // external bus
  input  word_t   ext_dat_i,
  input  logic    global_ack_i,
  output logic    sysram_stb_o,
  output logic    ext_cyc_o,
  // back to cpu
  output word_t   dat_o,
  output logic    ack_o
);

  logic  req_act;    // cyc and stb together
  logic  rom_part1;  // 160000-163777
  logic  rom_part2;  // 164000-172777
  logic  rom_part3;  // 173000-173777
  addr_t adr;

  assign adr     = req_i.adr;
  assign req_act = req_i.cyc & req_i.stb;

  //**************************************************
  // shadow rom windows
  //**************************************************
  // low part on with either startup bit
  assign rom_part1 = (adr[12:11] == 2'b00) & (startup_reg_i[2] | startup_reg_i[3]);
  // middle part only with bit 3
  assign rom_part2 = ((adr[12:11] == 2'b01) | (adr[12:11] == 2'b10)) & startup_reg_i[3];
  // loader block, always mapped
  assign rom_part3 = (adr[12:9] == 4'b1011);

  assign rom_stb_o = req_act & (adr[15:13] == ROM_PAGE)
                   & (rom_part1 | rom_part2 | rom_part3);

  // register block and system ram
  assign cpudev_stb_o = req_act & (adr[15:4] == CPUDEV_BASE[15:4]);  // 16 bytes
  assign sysram_stb_o = req_act & (adr[15:6] == SYSRAM_BASE[15:6]);  // 64 bytes

  // external cycle only when no local target answers
  assign ext_cyc_o = req_i.cyc & ~rom_stb_o & ~cpudev_stb_o;

  //**************************************************
  // read data and ack
  //**************************************************
  always_comb begin
    if (rom_stb_o) begin
      dat_o = rom_dat_i;            // shadow rom
    end else if (cpudev_stb_o) begin
      dat_o = cpudev_dat_i;         // register block
    end else begin
      dat_o = ext_dat_i;            // anything on the bus
    end
  end

  // any responder finishes the cycle
  assign ack_o = rom_ack_i | cpudev_ack_i | global_ack_i;

endmodule

// ==== design/shadow_rom.sv ====
//**************************************************
// shadow_rom
// 4K word monitor rom, synchronous read,
// ack delayed two cycles after the strobe
//**************************************************
`timescale 1ns/10ps

module shadow_rom
  import dvk_board_pkg::*;
(
  input  logic       clk_p,
  input  logic       arst_n_i,
  input  logic       cyc_i,    // bus cycle
  input  logic       stb_i,    // rom strobe from decode
  input  rom_index_t index_i,  // word index, adr[12:1]
  output word_t      dat_o,    // registered read data
  output logic       ack_o     // delayed ack
);

  word_t mem [ROM_WORDS];  // rom image
  word_t dat_q;
  logic  ack0_q;           // first shaper stage
  logic  ack1_q;           // second shaper stage

  initial begin
    $readmemh(ROM_IMAGE, mem);
  end

  // synchronous read, valid by the time ack rises
  always_ff @(posedge clk_p) begin
    dat_q <= mem[index_i];
  end

  //**************************************************
  // ack shaper
  //**************************************************
  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack0_q <= 1'b0;
      ack1_q <= 1'b0;
    end else begin
      ack0_q <= cyc_i & stb_i;   // request seen
      ack1_q <= cyc_i & ack0_q;  // one more cycle
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack1_q & cyc_i;  // no ack outside a cycle

endmodule

// ==== design/sel_regs.sv ====
//**************************************************
// sel_regs
// startup register (SEL1) and SEL2, loaded by
// DCLO and written through the cpu SEL strobes
//**************************************************
`timescale 1ns/10ps

module sel_regs
  import dvk_board_pkg::*;
(
  input  logic       clk_p,
  input  logic       arst_n_i,
  input  logic       dclo_i,     // power-on reset from the board
  input  logic [2:1] vm_sel_i,   // 2 - SEL2 177714, 1 - SEL1 177716
  input  logic       we_i,       // cpu write
  input  logic       adr0_i,     // odd byte address
  input  word_t      dat_i,      // cpu write data
  output word_t      startup_o,  // SEL1
  output word_t      sel2_o      // SEL2, even half
);

  word_t startup_q;
  word_t sel2_q;
  logic  sel2_wr;     // even SEL2 write
  logic  startup_wr;  // SEL1 write

  assign sel2_wr    = vm_sel_i[2] & we_i & ~adr0_i;
  assign startup_wr = vm_sel_i[1] & we_i;

  //**************************************************
  // startup register layout
  //**************************************************
  // 15:8 start address
  // 3    high rom part, 2 low rom part
  // 1:0  startup mode
  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      startup_q <= STARTUP_RESET;
      sel2_q    <= '0;
    end else if (dclo_i) begin
      startup_q <= STARTUP_RESET;  // held while DCLO is up
      sel2_q    <= '0;
    end else begin
      if (sel2_wr) begin
        sel2_q <= dat_i;  // full word
      end
      if (startup_wr) begin
        startup_q[7:2] <= dat_i[7:2];  // rest is read only
      end
    end
  end

  assign startup_o = startup_q;
  assign sel2_o    = sel2_q;

endmodule

// ==== design/board_timer.sv ====
//**************************************************
// board_timer
// cpu clock enable, 50 Hz tick and the debounced
// timer on/off button
//**************************************************
`timescale 1ns/10ps

module board_timer
  import dvk_board_pkg::*;
#(
  parameter int TICK_DIV = TICK_DIV_DEFAULT  // clocks per tick
) (
  input  logic clk_p,
  input  logic arst_n_i,
  input  logic button_i,       // timer button, active high
  output logic cpu_clk_ena_o,  // one pulse per CPU_ENA_DIV clocks
  output logic timer_irq_o,    // tick while timer is on
  output logic status_o        // timer on
);

  logic [CPU_ENA_W-1:0]       ena_cnt;
  logic                       ena_q;
  logic [$clog2(TICK_DIV)-1:0] tick_cnt;
  logic                       tick_q;    // 50 Hz pulse
  logic [1:0]                 btn_sh;    // button samples
  logic                       armed_q;   // toggle done, wait release
  logic                       status_q;

  //**************************************************
  // cpu clock enable
  //**************************************************
  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ena_cnt <= '0;
      ena_q   <= 1'b0;
    end else if (ena_cnt == CPU_ENA_W'(CPU_ENA_DIV - 1)) begin
      ena_cnt <= '0;
      ena_q   <= 1'b1;  // wrap
    end else begin
      ena_cnt <= ena_cnt + 1'b1;
      ena_q   <= 1'b0;
    end
  end

  //**************************************************
  // tick divider
  //**************************************************
  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tick_cnt <= '0;
      tick_q   <= 1'b0;
    end else if (tick_cnt == $bits(tick_cnt)'(TICK_DIV - 1)) begin
      tick_cnt <= '0;
      tick_q   <= 1'b1;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
      tick_q   <= 1'b0;
    end
  end

  // button debounce, sampled on ticks only
  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      btn_sh   <= '0;
      armed_q  <= 1'b0;
      status_q <= TIMER_INIT;
    end else if (tick_q) begin
      btn_sh <= {btn_sh[0], button_i};  // shift in
      if (&btn_sh) begin
        if (!armed_q) begin
          status_q <= ~status_q;  // steady press, toggle once
          armed_q  <= 1'b1;
        end
      end else if (~|btn_sh) begin
        armed_q <= 1'b0;  // steady release, rearm
      end
    end
  end

  assign cpu_clk_ena_o = ena_q;
  assign timer_irq_o   = tick_q & status_q;  // masked by status
  assign status_o      = status_q;

endmodule

// ==== design/dvk_board.sv ====
//**************************************************
// dvk_board
// DVK-1 processor board glue around the 1801VM1
// core: decode, shadow rom, SEL regs and timers
//**************************************************
`timescale 1ns/10ps

module dvk_board
  import dvk_board_pkg::*;
#(
  parameter int TICK_DIV = TICK_DIV_DEFAULT  // short in simulation
) (
  input  logic       clk_p,
  input  logic       arst_n_i,
  // cpu master side
  input  wb_req_t    cpu_req_i,
  output word_t      cpu_dat_o,
  output logic       cpu_ack_o,
  // external bus
  input  word_t      ext_dat_i,
  input  logic       global_ack_i,
  output logic       ext_cyc_o,
  output logic       sysram_stb_o,   // 177600-177677
  // cpu register block
  input  word_t      cpudev_dat_i,
  input  logic       cpudev_ack_i,
  output logic       cpudev_stb_o,
  input  logic [2:1] vm_sel_i,       // SEL register strobes
  // board control
  input  logic       dclo_i,
  input  logic       halt_i,         // console button
  input  logic       timer_button_i,
  output word_t      startup_reg_o,
  output word_t      sel2_o,
  output logic [3:1] vm_irq_o,       // fixed interrupt lines
  output logic       cpu_clk_ena_o,
  output logic       timer_status_o
);

  logic  rom_stb;
  logic  rom_ack;
  word_t rom_dat;
  word_t startup_reg;
  logic  timer_irq;

  //**************************************************
  // bus decode and shadow rom
  //**************************************************
  bus_decode u_decode (
    .req_i         (cpu_req_i),
    .startup_reg_i (startup_reg),
    .rom_dat_i     (rom_dat),
    .rom_ack_i     (rom_ack),
    .rom_stb_o     (rom_stb),
    .cpudev_dat_i  (cpudev_dat_i),
    .cpudev_ack_i  (cpudev_ack_i),
    .cpudev_stb_o  (cpudev_stb_o),
    .ext_dat_i     (ext_dat_i),
    .global_ack_i  (global_ack_i),
    .sysram_stb_o  (sysram_stb_o),
    .ext_cyc_o     (ext_cyc_o),
    .dat_o         (cpu_dat_o),
    .ack_o         (cpu_ack_o)
  );

  shadow_rom u_rom (
    .clk_p    (clk_p),
    .arst_n_i (arst_n_i),
    .cyc_i    (cpu_req_i.cyc),
    .stb_i    (rom_stb),
    .index_i  (cpu_req_i.adr[12:1]),  // word address
    .dat_o    (rom_dat),
    .ack_o    (rom_ack)
  );

  // SEL1 and SEL2
  sel_regs u_sel (
    .clk_p     (clk_p),
    .arst_n_i  (arst_n_i),
    .dclo_i    (dclo_i),
    .vm_sel_i  (vm_sel_i),
    .we_i      (cpu_req_i.we),
    .adr0_i    (cpu_req_i.adr[0]),
    .dat_i     (cpu_req_i.dat),
    .startup_o (startup_reg),
    .sel2_o    (sel2_o)
  );

  board_timer #(
    .TICK_DIV (TICK_DIV)
  ) u_timer (
    .clk_p         (clk_p),
    .arst_n_i      (arst_n_i),
    .button_i      (timer_button_i),
    .cpu_clk_ena_o (cpu_clk_ena_o),
    .timer_irq_o   (timer_irq),
    .status_o      (timer_status_o)
  );

  assign startup_reg_o = startup_reg;
  // 3 unused, 2 timer, 1 halt
  assign vm_irq_o      = {1'b0, timer_irq, halt_i};

endmodule

// ==== verif/dvk_board_checker.sv ====
//**************************************************
// dvk_board_checker
// bus strobe and interrupt line assertions,
// bound into dvk_board
//**************************************************
`timescale 1ns/10ps

module dvk_board_checker
  import dvk_board_pkg::*;
(
  input logic       clk_p,
  input logic       arst_n_i,
  input wb_req_t    cpu_req_i,
  input logic       rom_stb_i,     // internal rom strobe
  input logic       rom_ack_i,     // internal rom ack
  input logic       cpudev_stb_i,
  input logic       sysram_stb_i,
  input logic       ext_cyc_i,
  input logic [3:1] vm_irq_i
);

  int unsigned gate_fails   = 0;
  int unsigned strobe_fails = 0;
  int unsigned irq_fails    = 0;
  int unsigned ack_fails    = 0;
  int unsigned fail_total;  // read by the testbench

  assign fail_total = gate_fails + strobe_fails + irq_fails + ack_fails;

  // local targets keep the external bus idle
  ext_gate: assert property (@(posedge clk_p) disable iff (!arst_n_i)
    !(ext_cyc_i && (rom_stb_i || cpudev_stb_i)))
    else begin
      $error("ext_cyc_o high during a rom or register block access");
      gate_fails++;
    end

  one_strobe: assert property (@(posedge clk_p) disable iff (!arst_n_i)
    $onehot0({rom_stb_i, cpudev_stb_i, sysram_stb_i}))
    else begin
      $error("more than one target strobe high");
      strobe_fails++;
    end

  // line 3 is tied off on this board
  irq3_low: assert property (@(posedge clk_p) disable iff (!arst_n_i)
    !vm_irq_i[3])
    else begin
      $error("vm_irq_o[3] went high");
      irq_fails++;
    end

  rom_ack_cyc: assert property (@(posedge clk_p) disable iff (!arst_n_i)
    rom_ack_i |-> cpu_req_i.cyc)
    else begin
      $error("rom ack outside a bus cycle");
      ack_fails++;
    end

endmodule

// ==== verif/tb_dvk_board.sv ====
//**************************************************
// tb_dvk_board
// directed tests for the DVK-1 board glue: rom,
// decode, SEL registers, timer and interrupts
//**************************************************
`timescale 1ns/10ps

module tb_dvk_board
  import dvk_board_pkg::*;
();

  localparam int TICK  = 40;   // short tick divider
  localparam int LIMIT = 200;  // cycles before a wait gives up

  logic       clk_p = 1'b0;
  logic       arst_n_i;
  wb_req_t    cpu_req_i;
  word_t      ext_dat_i;
  word_t      cpudev_dat_i;
  logic       global_ack_i = 1'b0;  // driven by the slave model
  logic       cpudev_ack_i = 1'b0;
  logic [2:1] vm_sel_i;
  logic       dclo_i;
  logic       halt_i;
  logic       timer_button_i;
  word_t      cpu_dat_o;
  word_t      startup_reg_o;
  word_t      sel2_o;
  logic       cpu_ack_o;
  logic       ext_cyc_o;
  logic       sysram_stb_o;
  logic       cpudev_stb_o;
  logic       cpu_clk_ena_o;
  logic       timer_status_o;
  logic [3:1] vm_irq_o;

  int          errors   = 0;
  int          timeouts = 0;
  logic [31:0] lfsr     = 32'd71887;  // seed
  // results of the last bus cycle
  word_t       ext_word;
  word_t       dev_word;
  word_t       rd_dat;
  int          lat;
  logic        seen_ext;
  logic        seen_dev;
  logic        seen_ram;

  dvk_board #(.TICK_DIV(TICK)) dut0 (.*);

  bind dvk_board dvk_board_checker u_chk (
    .clk_p        (clk_p),
    .arst_n_i     (arst_n_i),
    .cpu_req_i    (cpu_req_i),
    .rom_stb_i    (rom_stb),
    .rom_ack_i    (rom_ack),
    .cpudev_stb_i (cpudev_stb_o),
    .sysram_stb_i (sysram_stb_o),
    .ext_cyc_i    (ext_cyc_o),
    .vm_irq_i     (vm_irq_o)
  );

  always #10 clk_p = ~clk_p;  // 20 ns

  // bus slave and register block answer one cycle after select
  always @(posedge clk_p) begin
    global_ack_i <= ext_cyc_o & cpu_req_i.stb;
    cpudev_ack_i <= cpudev_stb_o;
  end

  //**************************************************
  // helpers
  //**************************************************
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s = %o, expected %o", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hB4BC_D35C;  // galois taps
    end
    return s >> 1;
  endfunction

  task automatic rand_word(output word_t w);
    for (int i = 0; i < 16; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      w[i] = lfsr[0];
    end
  endtask

  // one cpu cycle, held until ack, then one idle cycle
  task automatic bus_cycle(input addr_t a, input logic we, input word_t wdat,
                           input logic [2:1] sel);
    rand_word(ext_word);
    rand_word(dev_word);
    @(posedge clk_p);
    cpu_req_i    <= '{adr: a, dat: wdat, we: we, sel: 2'b11, cyc: 1'b1, stb: 1'b1};
    vm_sel_i     <= sel;
    ext_dat_i    <= ext_word;
    cpudev_dat_i <= dev_word;
    lat      = 0;
    seen_ext = 1'b0;
    seen_dev = 1'b0;
    seen_ram = 1'b0;
    forever begin
      @(negedge clk_p);
      seen_ext |= ext_cyc_o;
      seen_dev |= cpudev_stb_o;
      seen_ram |= sysram_stb_o;
      if (cpu_ack_o || lat == LIMIT) break;
      lat++;
    end
    rd_dat = cpu_dat_o;
    if (!cpu_ack_o) begin
      timeouts++;
      $display("no acknowledge within %0d cycles for address %o", LIMIT, a);
    end
    @(posedge clk_p);
    cpu_req_i <= '0;  // cpu drops the request
    vm_sel_i  <= '0;
    repeat (2) @(negedge clk_p);
  endtask

  function automatic logic pulse_level(input int which);
    return (which == 0) ? cpu_clk_ena_o : vm_irq_o[2];
  endfunction

  // cycles between two pulses of clk_ena (0) or irq line 2 (1)
  task automatic pulse_gap(input int which, output int gap);
    int n;
    n   = 0;
    gap = 0;
    do begin
      @(negedge clk_p);
      n++;
    end while (!pulse_level(which) && n < LIMIT);
    do begin
      @(negedge clk_p);
      gap++;
    end while (!pulse_level(which) && gap < LIMIT);
    if (n == LIMIT || gap == LIMIT) begin
      timeouts++;
      $display("pulse %0d did not repeat within %0d cycles", which, LIMIT);
    end
  endtask

  task automatic wait_status(input logic exp);
    int n;
    n = 0;
    do begin
      @(negedge clk_p);
      n++;
    end while (timer_status_o !== exp && n < 4 * TICK);
    if (timer_status_o !== exp) begin
      timeouts++;
      $display("timer status did not turn %0d after the button press", exp);
    end
  endtask

  // status must hold and the timer irq stay quiet
  task automatic watch_quiet(input int cycles, input logic exp);
    logic moved;
    logic irq_seen;
    moved    = 1'b0;
    irq_seen = 1'b0;
    repeat (cycles) begin
      @(negedge clk_p);
      moved    |= (timer_status_o !== exp);
      irq_seen |= vm_irq_o[2];
    end
    check_value("timer_status_o moved", moved, 0);
    check_value("vm_irq_o[2] while off", irq_seen, 0);
  endtask

  task automatic dclo_pulse();
    @(posedge clk_p);
    dclo_i <= 1'b1;
    repeat (2) @(posedge clk_p);
    dclo_i <= 1'b0;
    @(negedge clk_p);
  endtask

  //**************************************************
  // directed tests
  //**************************************************
  task automatic reset_and_dclo();
    repeat (2) @(posedge clk_p);
    arst_n_i <= 1'b1;
    dclo_pulse();
    check_value("startup_reg_o", startup_reg_o, 16'o160005);
    check_value("sel2_o", sel2_o, 0);
    check_value("timer_status_o", timer_status_o, 1);
    check_value("cpu_ack_o", cpu_ack_o, 0);
    check_value("cpu_clk_ena_o", cpu_clk_ena_o, 0);
    check_value("vm_irq_o[2]", vm_irq_o[2], 0);
  endtask

  task automatic rom_reads();
    addr_t a;
    for (int i = 0; i < 32; i++) begin
      a = (i < 16) ? addr_t'(16'o160000 + 2 * i) : addr_t'(16'o173000 + 2 * (i - 16));
      bus_cycle(a, 1'b0, '0, 2'b00);
      check_value("cpu_dat_o", rd_dat, a);  // word holds its address
      check_value("rom ack latency", lat, 2);
      check_value("ext_cyc_o", seen_ext, 0);
    end
  endtask

  task automatic rom_windows();
    bus_cycle(16'o177716, 1'b1, 16'h0000, 2'b01);  // bits 3:2 off
    check_value("startup_reg_o", startup_reg_o, 16'o160001);
    bus_cycle(16'o160000, 1'b0, '0, 2'b00);
    check_value("ext_cyc_o", seen_ext, 1);
    check_value("cpu_dat_o", rd_dat, ext_word);
    bus_cycle(16'o173000, 1'b0, '0, 2'b00);        // loader block stays
    check_value("ext_cyc_o", seen_ext, 0);
    check_value("cpu_dat_o", rd_dat, 16'o173000);
    bus_cycle(16'o177716, 1'b1, 16'o000010, 2'b01);  // bit 3 only
    bus_cycle(16'o164000, 1'b0, '0, 2'b00);
    check_value("ext_cyc_o", seen_ext, 0);
    check_value("rom ack latency", lat, 2);
    bus_cycle(16'o160002, 1'b0, '0, 2'b00);
    check_value("cpu_dat_o", rd_dat, 16'o160002);
  endtask

  task automatic bus_routing();
    addr_t others [4];
    others = '{16'o000000, 16'o157776, 16'o177500, 16'o177720};
    for (int i = 0; i < 8; i++) begin
      bus_cycle(addr_t'(16'o177700 + 2 * i), 1'b0, '0, 2'b00);
      check_value("cpudev_stb_o", seen_dev, 1);
      check_value("ext_cyc_o", seen_ext, 0);
      check_value("cpu_dat_o", rd_dat, dev_word);
    end
    for (int i = 0; i < 4; i++) begin
      bus_cycle(addr_t'(16'o177600 + 16'o20 * i), 1'b0, '0, 2'b00);
      check_value("sysram_stb_o", seen_ram, 1);
      check_value("ext_cyc_o", seen_ext, 1);
      check_value("cpudev_stb_o", seen_dev, 0);
      check_value("cpu_dat_o", rd_dat, ext_word);
    end
    foreach (others[i]) begin
      bus_cycle(others[i], 1'b0, '0, 2'b00);
      check_value("ext_cyc_o", seen_ext, 1);
      check_value("sysram_stb_o", seen_ram, 0);
      check_value("cpudev_stb_o", seen_dev, 0);
      check_value("cpu_dat_o", rd_dat, ext_word);
    end
  endtask

  task automatic register_writes();
    word_t d;
    rand_word(d);
    bus_cycle(16'o177714, 1'b1, d, 2'b10);
    check_value("sel2_o", sel2_o, d);
    bus_cycle(16'o177715, 1'b1, ~d, 2'b10);  // odd byte, ignored
    check_value("sel2_o", sel2_o, d);
    bus_cycle(16'o177716, 1'b1, 16'hFFFF, 2'b01);
    // start address and mode keep their load value
    check_value("startup_reg_o", startup_reg_o, 16'o160375);
    dclo_pulse();
    check_value("startup_reg_o", startup_reg_o, 16'o160005);
    check_value("sel2_o", sel2_o, 0);
  endtask

  task automatic timer_and_irq();
    int gap;
    check_value("timer_status_o", timer_status_o, 1);
    pulse_gap(0, gap);
    check_value("cpu_clk_ena_o period", gap, 22);
    pulse_gap(1, gap);
    check_value("vm_irq_o[2] period", gap, TICK);
    @(posedge clk_p);
    halt_i <= 1'b1;
    @(negedge clk_p);
    check_value("vm_irq_o[1]", vm_irq_o[1], 1);
    @(posedge clk_p);
    halt_i <= 1'b0;
    @(negedge clk_p);
    check_value("vm_irq_o[1]", vm_irq_o[1], 0);
    // press, toggle off once
    @(posedge clk_p);
    timer_button_i <= 1'b1;
    wait_status(1'b0);
    watch_quiet(3 * TICK, 1'b0);
    @(posedge clk_p);
    timer_button_i <= 1'b0;
    watch_quiet(4 * TICK, 1'b0);  // release rearms
    @(posedge clk_p);
    timer_button_i <= 1'b1;
    wait_status(1'b1);
    @(posedge clk_p);
    timer_button_i <= 1'b0;
    pulse_gap(1, gap);
    check_value("vm_irq_o[2] period", gap, TICK);
  endtask

  //**************************************************
  // main sequence
  //**************************************************
  initial begin
    int asserts;
    arst_n_i       = 1'b0;
    cpu_req_i      = '0;
    ext_dat_i      = '0;
    cpudev_dat_i   = '0;
    vm_sel_i       = '0;
    dclo_i         = 1'b0;
    halt_i         = 1'b0;
    timer_button_i = 1'b0;
    reset_and_dclo();
    rom_reads();
    rom_windows();
    bus_routing();
    register_writes();
    timer_and_irq();
    asserts = int'(dut0.u_chk.fail_total);
    $display("errors %0d, timeouts %0d, assertion failures %0d", errors, timeouts, asserts);
    if (errors == 0 && timeouts == 0 && asserts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== dvk_board.f ====
design/dvk_board_pkg.sv
design/bus_decode.sv
design/shadow_rom.sv
design/sel_regs.sv
design/board_timer.sv
design/dvk_board.sv
verif/dvk_board_checker.sv
verif/tb_dvk_board.sv

// ==== Makefile ====
TOP := tb_dvk_board
OBJ := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): dvk_board.f design/*.sv design/shadow_rom.hex verif/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f dvk_board.f -Mdir $(OBJ)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f dvk_board.f

clean:
	rm -rf $(OBJ) sim.log

// ==== design/shadow_rom.hex ====
// @ lines give the rom word index (adr[12:1]) in hex
// each following line is one 16-bit word, its own byte address
@000
E000
E002
E004
E006
E008
E00A
E00C
E00E
E010
E012
E014
E016
E018
E01A
E01C
E01E
@B00
F600
F602
F604
F606
F608
F60A
F60C
F60E
F610
F612
F614
F616
F618
F61A
F61C
F61E
